// File: hw/conv_settings.svh
/*
 * Sizes and latencies of the convolution datapath
 */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Pixel and weight width
`define CONV_PIX_W      8
`define CONV_TAPS       4
`define CONV_IFM_ROWS   8
`define CONV_WGT_ROWS   4
`define CONV_COLS       5
`define CONV_ACC_W      25

// Pipeline depths in cycles
`define CONV_PE_LAT     3
`define CONV_TREE_LAT   2

`endif

// File: hw/conv_pkg.sv
/*
 * Pixel, word, partial-sum and result types, plus the controller states
 */
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;

    // Byte r of a word belongs to row r
    typedef pixel_t [`CONV_IFM_ROWS-1:0] ifm_word_t;
    typedef pixel_t [`CONV_WGT_ROWS-1:0] wgt_word_t;

    typedef logic signed [`CONV_ACC_W-1:0] psum_t;

    // Column sums leaving the PE array
    typedef struct packed {
        logic                       valid;
        logic                       last;
        psum_t [`CONV_COLS-1:0]     data;
    } col_psum_t;

    typedef struct packed {
        logic [$clog2(`CONV_COLS)-1:0] col;
        psum_t                         data;
    } result_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAIN,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/conv_ctrl.sv
/*
 * Job controller: load strobes, group counting, result drain and done pulse
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module conv_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  logic [1:0] cfg_ci_i,
    input  logic       xfer_i,
    output logic       read_o,
    output logic       calc_o,
    output logic       last_o,
    output logic       clr_o,
    output logic       done_o
);
    import conv_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic [1:0]  ci_q;
    logic [1:0]  tap_q;
    logic [1:0]  grp_q;
    logic [2:0]  xfer_cnt_q;
    logic        group_end;
    logic        job_end;
    logic        drain_end;

    assign read_o = (state_q == LOAD);
    assign clr_o  = (state_q == IDLE) && start_i;
    assign done_o = (state_q == DONE);

    // Fourth word of a group is being taken this cycle
    assign group_end = read_o && (tap_q == 2'(`CONV_TAPS - 1));
    assign job_end   = group_end && (grp_q == ci_q);
    assign drain_end = xfer_i && (xfer_cnt_q == 3'(`CONV_COLS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = LOAD;
            LOAD:    if (job_end) state_d = DRAIN;
            DRAIN:   if (drain_end) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            ci_q       <= '0;
            tap_q      <= '0;
            grp_q      <= '0;
            xfer_cnt_q <= '0;
            calc_o     <= 1'b0;
            last_o     <= 1'b0;
        end else begin
            state_q <= state_d;
            // Taps are complete in the cycle after the fourth load
            calc_o  <= group_end;
            last_o  <= job_end;
            if (clr_o) begin
                ci_q       <= cfg_ci_i;
                tap_q      <= '0;
                grp_q      <= '0;
                xfer_cnt_q <= '0;
            end
            if (read_o) begin
                tap_q <= tap_q + 2'd1;
                if (group_end)
                    grp_q <= grp_q + 2'd1;
            end
            if (state_q == DRAIN && xfer_i)
                xfer_cnt_q <= xfer_cnt_q + 3'd1;
        end
    end

    a_read_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        read_o |-> (state_q == LOAD) && (grp_q <= ci_q));

endmodule

`default_nettype wire

// File: hw/tap_buffer.sv
/*
 * Per-row tap shift registers, one new word per read strobe
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module tap_buffer #(
    parameter int ROWS = `CONV_IFM_ROWS
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           read_i,
    input  conv_pkg::pixel_t [ROWS-1:0]                    word_i,
    output conv_pkg::pixel_t [ROWS-1:0][`CONV_TAPS-1:0]    taps_o
);

    // Tap 0 holds the newest word of each row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps_o <= '0;
        end else if (read_i) begin
            for (int r = 0; r < ROWS; r++) begin
                taps_o[r] <= {taps_o[r][`CONV_TAPS-2:0], word_i[r]};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_pe.sv
/*
 * Processing element: four multiplies and a two-level adder, 3 pipeline stages
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module conv_pe (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  conv_pkg::pixel_t [`CONV_TAPS-1:0]    ifm_i,
    input  conv_pkg::pixel_t [`CONV_TAPS-1:0]    wgt_i,
    output conv_pkg::psum_t                      psum_o
);

    logic signed [2*`CONV_PIX_W-1:0] prod_q [`CONV_TAPS];
    logic signed [2*`CONV_PIX_W:0]   pair_q [2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `CONV_TAPS; k++) begin
                prod_q[k] <= '0;
            end
            pair_q[0] <= '0;
            pair_q[1] <= '0;
            psum_o    <= '0;
        end else begin
            for (int k = 0; k < `CONV_TAPS; k++) begin
                prod_q[k] <= $signed(ifm_i[k]) * $signed(wgt_i[k]);
            end
            // Pair sums need one extra bit
            pair_q[0] <= prod_q[0] + prod_q[1];
            pair_q[1] <= prod_q[2] + prod_q[3];
            psum_o    <= pair_q[0] + pair_q[1];
        end
    end

endmodule

`default_nettype wire

// File: hw/pe_array.sv
/*
 * 4x5 PE grid with per-column adder trees and the valid/last delay line
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module pe_array (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  conv_pkg::pixel_t [`CONV_IFM_ROWS-1:0][`CONV_TAPS-1:0] ifm_taps_i,
    input  conv_pkg::pixel_t [`CONV_WGT_ROWS-1:0][`CONV_TAPS-1:0] wgt_taps_i,
    input  logic                                                  calc_i,
    input  logic                                                  last_i,
    output conv_pkg::col_psum_t                                   col_o
);
    import conv_pkg::*;

    localparam int LAT = `CONV_PE_LAT + `CONV_TREE_LAT;

    psum_t          pe_sum [`CONV_WGT_ROWS][`CONV_COLS];
    psum_t          half_q [`CONV_COLS][2];
    psum_t          col_q  [`CONV_COLS];
    logic [LAT-1:0] valid_sr_q;
    logic [LAT-1:0] last_sr_q;

    // PE (r, c) pairs weight row r with input row r+c
    for (genvar r = 0; r < `CONV_WGT_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `CONV_COLS; c++) begin : g_col
            conv_pe u_pe (
                .clk    (clk),
                .rst_n  (rst_n),
                .ifm_i  (ifm_taps_i[r+c]),
                .wgt_i  (wgt_taps_i[r]),
                .psum_o (pe_sum[r][c])
            );
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < `CONV_COLS; c++) begin
            half_q[c][0] <= pe_sum[0][c] + pe_sum[1][c];
            half_q[c][1] <= pe_sum[2][c] + pe_sum[3][c];
            col_q[c]     <= half_q[c][0] + half_q[c][1];
        end
    end

    // Marks the column data in step with the PE and tree pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr_q <= '0;
            last_sr_q  <= '0;
        end else begin
            valid_sr_q <= {valid_sr_q[LAT-2:0], calc_i};
            last_sr_q  <= {last_sr_q[LAT-2:0], last_i};
        end
    end

    always_comb begin
        col_o.valid = valid_sr_q[LAT-1];
        col_o.last  = last_sr_q[LAT-1];
        for (int c = 0; c < `CONV_COLS; c++) begin
            col_o.data[c] = col_q[c];
        end
    end

    a_last_with_calc: assert property (@(posedge clk) disable iff (!rst_n)
        last_i |-> calc_i);

endmodule

`default_nettype wire

// File: hw/psum_accum.sv
/*
 * Column accumulator with clear, add, ReLU and a drain request
 */
`timescale 1ns/10ps
`default_nettype none

module psum_accum (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clr_i,
    input  logic            valid_i,
    input  logic            last_i,
    input  conv_pkg::psum_t psum_i,
    output logic            req_o,
    output conv_pkg::psum_t data_o,
    input  logic            gnt_i
);
    import conv_pkg::*;

    psum_t acc_q;
    psum_t sum;

    assign sum = acc_q + psum_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            req_o <= 1'b0;
        end else if (clr_i) begin
            acc_q <= '0;
            req_o <= 1'b0;
        end else begin
            if (valid_i)
                acc_q <= sum;
            if (valid_i && last_i)
                req_o <= 1'b1;
            else if (gnt_i)
                req_o <= 1'b0;
        end
    end

    // ReLU on the final group's total
    always_ff @(posedge clk) begin
        if (valid_i && last_i)
            data_o <= (sum < 0) ? '0 : sum;
    end

endmodule

`default_nettype wire

// File: hw/result_arbiter.sv
/*
 * Round-robin arbiter putting the column results on one valid/ready port
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module result_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [`CONV_COLS-1:0]                req_i,
    input  conv_pkg::psum_t [`CONV_COLS-1:0]     data_i,
    output logic [`CONV_COLS-1:0]                gnt_o,
    output conv_pkg::result_t                    out_o,
    output logic                                 out_valid_o,
    input  logic                                 out_ready_i,
    output logic                                 xfer_o
);
    import conv_pkg::*;

    localparam int IDX_W = $clog2(`CONV_COLS);

    logic [IDX_W-1:0] ptr_q;
    logic [IDX_W-1:0] win;
    logic             load;

    // Output register is free when empty or draining this cycle
    assign load   = (|req_i) && (!out_valid_o || out_ready_i);
    assign xfer_o = out_valid_o && out_ready_i;

    // First requester at or after the pointer
    always_comb begin : pick
        int   idx;
        logic found;
        win   = ptr_q;
        found = 1'b0;
        for (int i = 0; i < `CONV_COLS; i++) begin
            idx = (int'(ptr_q) + i) % `CONV_COLS;
            if (!found && req_i[idx]) begin
                win   = IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        if (load)
            gnt_o[win] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
            ptr_q       <= '0;
        end else if (load) begin
            out_valid_o <= 1'b1;
            ptr_q       <= (win == IDX_W'(`CONV_COLS - 1)) ? '0 : win + 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_o.col  <= win;
            out_o.data <= data_i[win];
        end
    end

    // At most one grant, and only to a column that is requesting
    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

`default_nettype wire

// File: hw/conv_top.sv
/*
 * Convolution pass top level: controller, tap buffers, PE array,
 * column accumulators and the result arbiter
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module conv_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic [1:0]          cfg_ci_i,
    input  conv_pkg::ifm_word_t ifm_i,
    input  conv_pkg::wgt_word_t wgt_i,
    output logic                ifm_read_o,
    output logic                wgt_read_o,
    output conv_pkg::result_t   out_o,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output logic                done_o
);
    import conv_pkg::*;

    logic                                         calc;
    logic                                         calc_last;
    logic                                         clr;
    logic                                         xfer;
    pixel_t [`CONV_IFM_ROWS-1:0][`CONV_TAPS-1:0]  ifm_taps;
    pixel_t [`CONV_WGT_ROWS-1:0][`CONV_TAPS-1:0]  wgt_taps;
    col_psum_t                                    col;
    logic [`CONV_COLS-1:0]                        req;
    logic [`CONV_COLS-1:0]                        gnt;
    psum_t [`CONV_COLS-1:0]                       acc_data;

    // Input and weight words are always read together
    assign wgt_read_o = ifm_read_o;

    conv_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .cfg_ci_i (cfg_ci_i),
        .xfer_i   (xfer),
        .read_o   (ifm_read_o),
        .calc_o   (calc),
        .last_o   (calc_last),
        .clr_o    (clr),
        .done_o   (done_o)
    );

    tap_buffer #(.ROWS(`CONV_IFM_ROWS)) u_ifm_taps (
        .clk    (clk),
        .rst_n  (rst_n),
        .read_i (ifm_read_o),
        .word_i (ifm_i),
        .taps_o (ifm_taps)
    );

    tap_buffer #(.ROWS(`CONV_WGT_ROWS)) u_wgt_taps (
        .clk    (clk),
        .rst_n  (rst_n),
        .read_i (wgt_read_o),
        .word_i (wgt_i),
        .taps_o (wgt_taps)
    );

    pe_array u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .ifm_taps_i (ifm_taps),
        .wgt_taps_i (wgt_taps),
        .calc_i     (calc),
        .last_i     (calc_last),
        .col_o      (col)
    );

    for (genvar c = 0; c < `CONV_COLS; c++) begin : g_acc
        psum_accum u_acc (
            .clk     (clk),
            .rst_n   (rst_n),
            .clr_i   (clr),
            .valid_i (col.valid),
            .last_i  (col.last),
            .psum_i  (col.data[c]),
            .req_o   (req[c]),
            .data_o  (acc_data[c]),
            .gnt_i   (gnt[c])
        );
    end

    result_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .data_i      (acc_data),
        .gnt_o       (gnt),
        .out_o       (out_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .xfer_o      (xfer)
    );

endmodule

`default_nettype wire

// File: verification/conv_tb.sv
/*
 * Testbench for conv_top: job table, column reference model, drive and checks
 */
`timescale 1ns/10ps
`default_nettype none

`include "conv_settings.svh"

module conv_tb;
    import conv_pkg::*;

    localparam int N_JOBS    = 10;
    localparam int MAX_WORDS = 16;

    // One job: group count minus one and up to four groups of words
    typedef struct packed {
        logic [1:0]                ci;
        ifm_word_t [MAX_WORDS-1:0] ifm;
        wgt_word_t [MAX_WORDS-1:0] wgt;
    } job_t;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [1:0]  cfg_ci;
    ifm_word_t   ifm_word;
    wgt_word_t   wgt_word;
    logic        ifm_read;
    logic        wgt_read;
    result_t     res;
    logic        res_valid;
    logic        res_ready;
    logic        done;

    job_t        jobs     [N_JOBS];
    string       job_name [N_JOBS];
    int          exp_tab  [N_JOBS][`CONV_COLS];
    logic [31:0] lcg_state;
    int          n_errors;
    int          n_checks;
    int          cycle_cnt;
    int          timeout_limit;

    conv_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .cfg_ci_i    (cfg_ci),
        .ifm_i       (ifm_word),
        .wgt_i       (wgt_word),
        .ifm_read_o  (ifm_read),
        .wgt_read_o  (wgt_read),
        .out_o       (res),
        .out_valid_o (res_valid),
        .out_ready_i (res_ready),
        .done_o      (done)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        n_errors++;
        $display("Fail %s: expected %0d, got %0d", name, expected, actual);
    endtask

    task automatic note_error(input string msg);
        n_errors++;
        $display("Error: %s", msg);
    endtask

    // Sum over taps and rows, ReLU at the end
    function automatic int column_model(input job_t job, input int c);
        int acc;
        acc = 0;
        for (int w = 0; w < 4 * (int'(job.ci) + 1); w++) begin
            for (int r = 0; r < `CONV_WGT_ROWS; r++) begin
                acc += int'($signed(job.ifm[w][r+c])) * int'($signed(job.wgt[w][r]));
            end
        end
        return (acc < 0) ? 0 : acc;
    endfunction

    task automatic fill_const(input int j, input int groups, input pixel_t ifm_v,
                              input pixel_t wgt_v);
        for (int w = 0; w < 4 * groups; w++) begin
            for (int r = 0; r < `CONV_IFM_ROWS; r++)
                jobs[j].ifm[w][r] = ifm_v;
            for (int r = 0; r < `CONV_WGT_ROWS; r++)
                jobs[j].wgt[w][r] = wgt_v;
        end
    endtask

    task automatic build_jobs();
        logic [31:0] rnd;
        for (int j = 0; j < N_JOBS; j++)
            jobs[j] = '0;
        job_name[0] = "all_zero";
        job_name[1] = "max_mag";
        fill_const(1, 1, 8'h80, 8'h80);
        job_name[2] = "neg_products";
        fill_const(2, 1, 8'h7f, 8'h80);
        // Upper rows negative, so the right-hand columns go below zero
        job_name[3] = "mixed_sign";
        fill_const(3, 1, 8'sd50, 8'sd10);
        for (int w = 0; w < 4; w++) begin
            for (int r = 4; r < `CONV_IFM_ROWS; r++)
                jobs[3].ifm[w][r] = -8'sd60;
        end
        job_name[4] = "max_mag_4grp";
        jobs[4].ci  = 2'd3;
        fill_const(4, 4, 8'h80, 8'h80);
        for (int j = 5; j < N_JOBS; j++) begin
            job_name[j] = $sformatf("random_%0d", j);
            jobs[j].ci  = 2'((j - 5) % 4);
            for (int w = 0; w < MAX_WORDS; w++) begin
                for (int r = 0; r < `CONV_IFM_ROWS; r++) begin
                    rnd = lcg_next();
                    jobs[j].ifm[w][r] = rnd[23:16];
                end
                for (int r = 0; r < `CONV_WGT_ROWS; r++) begin
                    rnd = lcg_next();
                    jobs[j].wgt[w][r] = rnd[23:16];
                end
            end
        end
    endtask

    task automatic run_job(input int j);
        int                    n_words;
        int                    word_idx;
        int                    first_read;
        int                    last_read;
        int                    n_res;
        int                    fifth_cyc;
        int                    cyc;
        int                    col;
        logic [`CONV_COLS-1:0] seen;
        logic                  finished;
        logic                  hold;
        result_t               prev_res;
        logic [31:0]           rnd;

        n_words    = 4 * (int'(jobs[j].ci) + 1);
        word_idx   = 0;
        first_read = -1;
        last_read  = -1;
        n_res      = 0;
        fifth_cyc  = -1;
        seen       = '0;
        finished   = 1'b0;
        hold       = 1'b0;
        prev_res   = '0;

        start  = 1'b1;
        cfg_ci = jobs[j].ci;
        @(negedge clk);
        start = 1'b0;
        cyc   = 1;
        while (!finished) begin
            n_checks++;
            if (ifm_read !== wgt_read)
                note_error($sformatf("%s: ifm and wgt read strobes differ", job_name[j]));
            // A word shown while the strobe is high is taken at the next rising edge
            if (ifm_read === 1'b1) begin
                if (first_read < 0)
                    first_read = cyc;
                last_read = cyc;
                if (word_idx < n_words) begin
                    ifm_word = jobs[j].ifm[word_idx];
                    wgt_word = jobs[j].wgt[word_idx];
                end
                word_idx++;
            end
            if (hold) begin
                n_checks++;
                if (res_valid !== 1'b1)
                    note_error($sformatf("%s: out_valid_o dropped while stalled", job_name[j]));
                else if (res !== prev_res)
                    report_mismatch({job_name[j], " stalled out_o"}, int'(prev_res), int'(res));
            end
            rnd       = lcg_next();
            res_ready = (rnd[23:16] % 8'd10) >= 8'd3;
            if (res_valid === 1'b1 && res_ready) begin
                col = int'(res.col);
                n_res++;
                n_checks++;
                if (n_res == `CONV_COLS)
                    fifth_cyc = cyc;
                if (n_res > `CONV_COLS)
                    note_error($sformatf("%s: extra result for column %0d", job_name[j], col));
                else if (col >= `CONV_COLS)
                    note_error($sformatf("%s: result has bad column tag %0d", job_name[j], col));
                else if (seen[col])
                    note_error($sformatf("%s: duplicate result for column %0d", job_name[j], col));
                else begin
                    seen[col] = 1'b1;
                    if (int'(res.data) != exp_tab[j][col])
                        report_mismatch($sformatf("%s col%0d", job_name[j], col),
                                        exp_tab[j][col], int'(res.data));
                end
            end
            hold     = (res_valid === 1'b1) && !res_ready;
            prev_res = res;
            if (done === 1'b1) begin
                n_checks++;
                if (n_res != `CONV_COLS)
                    note_error($sformatf("%s: done_o came after %0d results", job_name[j], n_res));
                else if (cyc != fifth_cyc + 1)
                    note_error($sformatf("%s: done_o not one cycle after the fifth result",
                                         job_name[j]));
                finished = 1'b1;
            end
            @(negedge clk);
            cyc++;
        end

        // Quiet gap between jobs
        res_ready = 1'b1;
        repeat (3) begin
            n_checks++;
            if (done !== 1'b0)
                note_error($sformatf("%s: done_o high for more than one cycle", job_name[j]));
            if (res_valid !== 1'b0)
                note_error($sformatf("%s: extra result after done_o", job_name[j]));
            if (ifm_read !== 1'b0)
                note_error($sformatf("%s: read strobe high after done_o", job_name[j]));
            @(negedge clk);
        end

        n_checks++;
        if (word_idx != n_words)
            report_mismatch({job_name[j], " read cycles"}, n_words, word_idx);
        else if (first_read != 1 || last_read - first_read + 1 != n_words)
            note_error($sformatf("%s: read strobes not one run starting after start_i",
                                 job_name[j]));
        for (int c = 0; c < `CONV_COLS; c++) begin
            if (!seen[c])
                note_error($sformatf("%s: missing result for column %0d", job_name[j], c));
        end
    endtask

    initial begin : main
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        cfg_ci    = '0;
        ifm_word  = '0;
        wgt_word  = '0;
        res_ready = 1'b0;
        n_errors  = 0;
        n_checks  = 0;
        lcg_state = 32'd2212;

        build_jobs();
        timeout_limit = 0;
        for (int j = 0; j < N_JOBS; j++) begin
            for (int c = 0; c < `CONV_COLS; c++)
                exp_tab[j][c] = column_model(jobs[j], c);
            timeout_limit += 4 * (4 * (int'(jobs[j].ci) + 1) + 40);
        end

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        n_checks++;
        if (ifm_read !== 1'b0 || res_valid !== 1'b0 || done !== 1'b0)
            note_error("read strobe, out_valid_o or done_o not low after reset");

        for (int j = 0; j < N_JOBS; j++)
            run_job(j);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/tap_buffer.sv
hw/conv_pe.sv
hw/pe_array.sv
hw/psum_accum.sv
hw/result_arbiter.sv
hw/conv_top.sv
verification/conv_tb.sv

// File: Makefile
# Verilator flow for the convolution pass testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
